// ==== mesh_config.svh ====
/*
 * Build-time sizing for the 2x2 mesh NoC.
 * Address is {x, y}, so MESH_ADDR_WIDTH must stay twice MESH_COORD_WIDTH.
 * The testbench draws destinations from 2 random bits and assumes MESH_DIM of 2.
 */
`ifndef MESH_CONFIG_SVH
`define MESH_CONFIG_SVH

// Payload carried by each packet
`define MESH_DATA_WIDTH 32

// Width of one X or Y coordinate
`define MESH_COORD_WIDTH 4

`define MESH_ADDR_WIDTH (2 * `MESH_COORD_WIDTH)

// Entries per router input FIFO
`define MESH_FIFO_DEPTH 4

// Nodes per side of the mesh
`define MESH_DIM 2

`endif

// ==== mesh_pkg.sv ====
/*
 * Shared types for the mesh routers.
 * packet_t packs dest_x, dest_y and data, so a flat {addr, data} word casts to it.
 */
`include "mesh_config.svh"

package mesh_pkg;

    localparam int NUM_PORTS = 5;

    // Router port indices, also used to index per-port arrays
    typedef enum logic [2:0] {
        NORTH = 3'd0,
        EAST  = 3'd1,
        SOUTH = 3'd2,
        WEST  = 3'd3,
        LOCAL = 3'd4
    } port_e;

    // X sits in the upper half of the address
    typedef struct packed {
        logic [`MESH_COORD_WIDTH-1:0] dest_x;
        logic [`MESH_COORD_WIDTH-1:0] dest_y;
        logic [`MESH_DATA_WIDTH-1:0]  data;
    } packet_t;

endpackage

// ==== mesh_input_fifo.sv ====
/*
 * Circular packet FIFO for one router input.
 * Push is ignored when full, pop is ignored when empty.
 * The head is read combinationally from storage and has no reset.
 */
`timescale 1ns/1ps
`include "mesh_config.svh"

module mesh_input_fifo (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              push_i,
    input  mesh_pkg::packet_t push_pkt_i,
    input  logic              pop_i,
    output mesh_pkg::packet_t head_pkt_o,
    output logic              empty_o,
    output logic              full_o
);

    localparam int DEPTH = `MESH_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    mesh_pkg::packet_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    // Wrap at DEPTH so non power of two depths also work
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        nxt = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
        return nxt;
    endfunction

    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == CNT_W'(DEPTH));

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    // Head is visible right after the edge that writes it
    assign head_pkt_o = mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push_pkt_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            // Simultaneous push and pop leaves the count alone
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (!do_push && do_pop) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

// ==== mesh_rr_arbiter.sv ====
/*
 * Round-robin arbiter for one router output.
 * A grant is held until advance_i, so a stalled output keeps its source.
 * Requests must stay high until their grant advances.
 */
`timescale 1ns/1ps

module mesh_rr_arbiter (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [mesh_pkg::NUM_PORTS-1:0] req_i,
    input  logic                           advance_i,
    output logic [mesh_pkg::NUM_PORTS-1:0] grant_o
);

    localparam int N    = mesh_pkg::NUM_PORTS;
    localparam int PTR_W = $clog2(N);

    logic [PTR_W-1:0] ptr_q;
    logic [N-1:0]     held_q;
    logic [N-1:0]     fresh_grant;
    logic [PTR_W-1:0] grant_idx;
    logic [PTR_W-1:0] ptr_next;

    // First requester at or after the pointer
    always_comb begin
        int  idx;
        logic found;
        fresh_grant = '0;
        found       = 1'b0;
        for (int k = 0; k < N; k++) begin
            idx = int'(ptr_q) + k;
            if (idx >= N) begin
                idx = idx - N;
            end
            if (!found && req_i[idx]) begin
                fresh_grant[idx] = 1'b1;
                found            = 1'b1;
            end
        end
    end

    // Keep last cycle's winner while it still asks
    assign grant_o = (|(held_q & req_i)) ? held_q : fresh_grant;

    always_comb begin
        grant_idx = '0;
        for (int k = 0; k < N; k++) begin
            if (grant_o[k]) begin
                grant_idx = PTR_W'(k);
            end
        end
    end

    assign ptr_next = (grant_idx == PTR_W'(N - 1)) ? '0 : grant_idx + 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr_q  <= '0;
            held_q <= '0;
        end else if (advance_i) begin
            ptr_q  <= ptr_next;
            held_q <= '0;
        end else begin
            held_q <= grant_o;
        end
    end

endmodule

// ==== mesh_router.sv ====
/*
 * Five-port XY router, one packet per transfer.
 * X is resolved before Y; a packet for this node's coordinates leaves on LOCAL.
 * Output valid never looks at the downstream ready.
 */
`timescale 1ns/1ps
`include "mesh_config.svh"

module mesh_router #(
    parameter logic [`MESH_COORD_WIDTH-1:0] X_COORD = '0,
    parameter logic [`MESH_COORD_WIDTH-1:0] Y_COORD = '0
) (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic                        north_valid_i,
    input  logic [`MESH_DATA_WIDTH-1:0] north_data_i,
    input  logic [`MESH_ADDR_WIDTH-1:0] north_addr_i,
    output logic                        north_ready_o,
    output logic                        north_valid_o,
    output logic [`MESH_DATA_WIDTH-1:0] north_data_o,
    output logic [`MESH_ADDR_WIDTH-1:0] north_addr_o,
    input  logic                        north_ready_i,

    input  logic                        east_valid_i,
    input  logic [`MESH_DATA_WIDTH-1:0] east_data_i,
    input  logic [`MESH_ADDR_WIDTH-1:0] east_addr_i,
    output logic                        east_ready_o,
    output logic                        east_valid_o,
    output logic [`MESH_DATA_WIDTH-1:0] east_data_o,
    output logic [`MESH_ADDR_WIDTH-1:0] east_addr_o,
    input  logic                        east_ready_i,

    input  logic                        south_valid_i,
    input  logic [`MESH_DATA_WIDTH-1:0] south_data_i,
    input  logic [`MESH_ADDR_WIDTH-1:0] south_addr_i,
    output logic                        south_ready_o,
    output logic                        south_valid_o,
    output logic [`MESH_DATA_WIDTH-1:0] south_data_o,
    output logic [`MESH_ADDR_WIDTH-1:0] south_addr_o,
    input  logic                        south_ready_i,

    input  logic                        west_valid_i,
    input  logic [`MESH_DATA_WIDTH-1:0] west_data_i,
    input  logic [`MESH_ADDR_WIDTH-1:0] west_addr_i,
    output logic                        west_ready_o,
    output logic                        west_valid_o,
    output logic [`MESH_DATA_WIDTH-1:0] west_data_o,
    output logic [`MESH_ADDR_WIDTH-1:0] west_addr_o,
    input  logic                        west_ready_i,

    input  logic                        local_valid_i,
    input  logic [`MESH_DATA_WIDTH-1:0] local_data_i,
    input  logic [`MESH_ADDR_WIDTH-1:0] local_addr_i,
    output logic                        local_ready_o,
    output logic                        local_valid_o,
    output logic [`MESH_DATA_WIDTH-1:0] local_data_o,
    output logic [`MESH_ADDR_WIDTH-1:0] local_addr_o,
    input  logic                        local_ready_i
);

    localparam int NP = mesh_pkg::NUM_PORTS;

    logic [NP-1:0]     in_valid;
    logic [NP-1:0]     in_ready;
    logic [NP-1:0]     out_valid;
    logic [NP-1:0]     out_ready;
    logic [NP-1:0]     fifo_empty;
    logic [NP-1:0]     fifo_full;
    logic [NP-1:0]     fifo_pop;
    mesh_pkg::packet_t in_pkt   [NP];
    mesh_pkg::packet_t head_pkt [NP];
    mesh_pkg::packet_t out_pkt  [NP];
    mesh_pkg::port_e   route    [NP];
    // gnt[output][input]
    logic [NP-1:0]     gnt      [NP];

    // Bit order follows port_e with north as bit 0 and local as bit 4
    assign in_valid  = {local_valid_i, west_valid_i, south_valid_i, east_valid_i, north_valid_i};
    assign out_ready = {local_ready_i, west_ready_i, south_ready_i, east_ready_i, north_ready_i};

    assign in_pkt[mesh_pkg::NORTH] = {north_addr_i, north_data_i};
    assign in_pkt[mesh_pkg::EAST]  = {east_addr_i, east_data_i};
    assign in_pkt[mesh_pkg::SOUTH] = {south_addr_i, south_data_i};
    assign in_pkt[mesh_pkg::WEST]  = {west_addr_i, west_data_i};
    assign in_pkt[mesh_pkg::LOCAL] = {local_addr_i, local_data_i};

    assign north_ready_o = in_ready[mesh_pkg::NORTH];
    assign east_ready_o  = in_ready[mesh_pkg::EAST];
    assign south_ready_o = in_ready[mesh_pkg::SOUTH];
    assign west_ready_o  = in_ready[mesh_pkg::WEST];
    assign local_ready_o = in_ready[mesh_pkg::LOCAL];

    assign north_valid_o = out_valid[mesh_pkg::NORTH];
    assign east_valid_o  = out_valid[mesh_pkg::EAST];
    assign south_valid_o = out_valid[mesh_pkg::SOUTH];
    assign west_valid_o  = out_valid[mesh_pkg::WEST];
    assign local_valid_o = out_valid[mesh_pkg::LOCAL];

    assign north_data_o = out_pkt[mesh_pkg::NORTH].data;
    assign east_data_o  = out_pkt[mesh_pkg::EAST].data;
    assign south_data_o = out_pkt[mesh_pkg::SOUTH].data;
    assign west_data_o  = out_pkt[mesh_pkg::WEST].data;
    assign local_data_o = out_pkt[mesh_pkg::LOCAL].data;

    assign north_addr_o = {out_pkt[mesh_pkg::NORTH].dest_x, out_pkt[mesh_pkg::NORTH].dest_y};
    assign east_addr_o  = {out_pkt[mesh_pkg::EAST].dest_x, out_pkt[mesh_pkg::EAST].dest_y};
    assign south_addr_o = {out_pkt[mesh_pkg::SOUTH].dest_x, out_pkt[mesh_pkg::SOUTH].dest_y};
    assign west_addr_o  = {out_pkt[mesh_pkg::WEST].dest_x, out_pkt[mesh_pkg::WEST].dest_y};
    assign local_addr_o = {out_pkt[mesh_pkg::LOCAL].dest_x, out_pkt[mesh_pkg::LOCAL].dest_y};

    for (genvar i = 0; i < NP; i++) begin : gen_in
        mesh_pkg::port_e dir;

        mesh_input_fifo u_fifo (
            .clk        (clk),
            .rst_n      (rst_n),
            .push_i     (in_valid[i]),
            .push_pkt_i (in_pkt[i]),
            .pop_i      (fifo_pop[i]),
            .head_pkt_o (head_pkt[i]),
            .empty_o    (fifo_empty[i]),
            .full_o     (fifo_full[i])
        );

        assign in_ready[i] = ~fifo_full[i];

        // XY decision on the head packet
        always_comb begin
            if (head_pkt[i].dest_x == X_COORD && head_pkt[i].dest_y == Y_COORD) begin
                dir = mesh_pkg::LOCAL;
            end else if (head_pkt[i].dest_x > X_COORD) begin
                dir = mesh_pkg::EAST;
            end else if (head_pkt[i].dest_x < X_COORD) begin
                dir = mesh_pkg::WEST;
            end else if (head_pkt[i].dest_y > Y_COORD) begin
                dir = mesh_pkg::SOUTH;
            end else begin
                dir = mesh_pkg::NORTH;
            end
        end

        assign route[i] = dir;

        // Leave the FIFO on the edge our output transfers
        assign fifo_pop[i] = gnt[route[i]][i] & out_ready[route[i]];
    end

    for (genvar j = 0; j < NP; j++) begin : gen_out
        logic [NP-1:0]     req;
        mesh_pkg::packet_t sel_pkt;

        always_comb begin
            for (int i = 0; i < NP; i++) begin
                req[i] = !fifo_empty[i] && (int'(route[i]) == j);
            end
        end

        mesh_rr_arbiter u_arb (
            .clk       (clk),
            .rst_n     (rst_n),
            .req_i     (req),
            .advance_i (out_valid[j] & out_ready[j]),
            .grant_o   (gnt[j])
        );

        assign out_valid[j] = |gnt[j];

        always_comb begin
            sel_pkt = '0;
            for (int i = 0; i < NP; i++) begin
                if (gnt[j][i]) begin
                    sel_pkt = head_pkt[i];
                end
            end
        end

        assign out_pkt[j] = sel_pkt;
    end

endmodule

// ==== mesh_2x2_top.sv ====
/*
 * Square mesh of XY routers, MESH_DIM per side, node index y*MESH_DIM+x.
 * Edge inputs never send and edge outputs always accept, so
 * packets addressed outside the mesh are silently dropped.
 */
`timescale 1ns/1ps
`include "mesh_config.svh"

module mesh_2x2_top (
    input  logic                                                     clk,
    input  logic                                                     rst_n,
    input  logic [`MESH_DIM*`MESH_DIM-1:0]                           local_valid_i,
    input  logic [`MESH_DIM*`MESH_DIM-1:0][`MESH_DATA_WIDTH-1:0]     local_data_i,
    input  logic [`MESH_DIM*`MESH_DIM-1:0][`MESH_ADDR_WIDTH-1:0]     local_addr_i,
    output logic [`MESH_DIM*`MESH_DIM-1:0]                           local_ready_o,
    output logic [`MESH_DIM*`MESH_DIM-1:0]                           local_valid_o,
    output logic [`MESH_DIM*`MESH_DIM-1:0][`MESH_DATA_WIDTH-1:0]     local_data_o,
    output logic [`MESH_DIM*`MESH_DIM-1:0][`MESH_ADDR_WIDTH-1:0]     local_addr_o,
    input  logic [`MESH_DIM*`MESH_DIM-1:0]                           local_ready_i
);

    localparam int DIM   = `MESH_DIM;
    localparam int NODES = DIM * DIM;
    localparam int DW    = `MESH_DATA_WIDTH;
    localparam int AW    = `MESH_ADDR_WIDTH;
    localparam int CW    = `MESH_COORD_WIDTH;

    // Link signals indexed [direction][node], direction as in port_e
    logic [3:0][NODES-1:0]         in_valid;
    logic [3:0][NODES-1:0][DW-1:0] in_data;
    logic [3:0][NODES-1:0][AW-1:0] in_addr;
    logic [3:0][NODES-1:0]         in_ready;
    logic [3:0][NODES-1:0]         out_valid;
    logic [3:0][NODES-1:0][DW-1:0] out_data;
    logic [3:0][NODES-1:0][AW-1:0] out_addr;
    logic [3:0][NODES-1:0]         out_ready;

    for (genvar n = 0; n < NODES; n++) begin : gen_node
        mesh_router #(
            .X_COORD (CW'(n % DIM)),
            .Y_COORD (CW'(n / DIM))
        ) u_router (
            .clk           (clk),
            .rst_n         (rst_n),
            .north_valid_i (in_valid[mesh_pkg::NORTH][n]),
            .north_data_i  (in_data[mesh_pkg::NORTH][n]),
            .north_addr_i  (in_addr[mesh_pkg::NORTH][n]),
            .north_ready_o (in_ready[mesh_pkg::NORTH][n]),
            .north_valid_o (out_valid[mesh_pkg::NORTH][n]),
            .north_data_o  (out_data[mesh_pkg::NORTH][n]),
            .north_addr_o  (out_addr[mesh_pkg::NORTH][n]),
            .north_ready_i (out_ready[mesh_pkg::NORTH][n]),
            .east_valid_i  (in_valid[mesh_pkg::EAST][n]),
            .east_data_i   (in_data[mesh_pkg::EAST][n]),
            .east_addr_i   (in_addr[mesh_pkg::EAST][n]),
            .east_ready_o  (in_ready[mesh_pkg::EAST][n]),
            .east_valid_o  (out_valid[mesh_pkg::EAST][n]),
            .east_data_o   (out_data[mesh_pkg::EAST][n]),
            .east_addr_o   (out_addr[mesh_pkg::EAST][n]),
            .east_ready_i  (out_ready[mesh_pkg::EAST][n]),
            .south_valid_i (in_valid[mesh_pkg::SOUTH][n]),
            .south_data_i  (in_data[mesh_pkg::SOUTH][n]),
            .south_addr_i  (in_addr[mesh_pkg::SOUTH][n]),
            .south_ready_o (in_ready[mesh_pkg::SOUTH][n]),
            .south_valid_o (out_valid[mesh_pkg::SOUTH][n]),
            .south_data_o  (out_data[mesh_pkg::SOUTH][n]),
            .south_addr_o  (out_addr[mesh_pkg::SOUTH][n]),
            .south_ready_i (out_ready[mesh_pkg::SOUTH][n]),
            .west_valid_i  (in_valid[mesh_pkg::WEST][n]),
            .west_data_i   (in_data[mesh_pkg::WEST][n]),
            .west_addr_i   (in_addr[mesh_pkg::WEST][n]),
            .west_ready_o  (in_ready[mesh_pkg::WEST][n]),
            .west_valid_o  (out_valid[mesh_pkg::WEST][n]),
            .west_data_o   (out_data[mesh_pkg::WEST][n]),
            .west_addr_o   (out_addr[mesh_pkg::WEST][n]),
            .west_ready_i  (out_ready[mesh_pkg::WEST][n]),
            .local_valid_i (local_valid_i[n]),
            .local_data_i  (local_data_i[n]),
            .local_addr_i  (local_addr_i[n]),
            .local_ready_o (local_ready_o[n]),
            .local_valid_o (local_valid_o[n]),
            .local_data_o  (local_data_o[n]),
            .local_addr_o  (local_addr_o[n]),
            .local_ready_i (local_ready_i[n])
        );

        for (genvar d = 0; d < 4; d++) begin : gen_link
            // Neighbour in direction d, and the port that faces back at us
            localparam int NX  = (n % DIM) + int'(d == mesh_pkg::EAST) - int'(d == mesh_pkg::WEST);
            localparam int NY  = (n / DIM) + int'(d == mesh_pkg::SOUTH)
                                 - int'(d == mesh_pkg::NORTH);
            localparam int OPP = (d + 2) % 4;

            if (NX >= 0 && NX < DIM && NY >= 0 && NY < DIM) begin : gen_inner
                assign in_valid[d][n]  = out_valid[OPP][NY * DIM + NX];
                assign in_data[d][n]   = out_data[OPP][NY * DIM + NX];
                assign in_addr[d][n]   = out_addr[OPP][NY * DIM + NX];
                assign out_ready[d][n] = in_ready[OPP][NY * DIM + NX];
            end else begin : gen_edge
                assign in_valid[d][n]  = 1'b0;
                assign in_data[d][n]   = '0;
                assign in_addr[d][n]   = '0;
                assign out_ready[d][n] = 1'b1;
            end
        end
    end

endmodule

// ==== mesh_properties.sv ====
/*
 * Handshake checks on the mesh local outputs, bound into the top level.
 * Covers only the local ports; inner links are not observed.
 */
`timescale 1ns/1ps
`include "mesh_config.svh"

module mesh_properties (
    input logic                                                 clk,
    input logic                                                 rst_n,
    input logic [`MESH_DIM*`MESH_DIM-1:0]                       local_valid_o,
    input logic [`MESH_DIM*`MESH_DIM-1:0][`MESH_DATA_WIDTH-1:0] local_data_o,
    input logic [`MESH_DIM*`MESH_DIM-1:0][`MESH_ADDR_WIDTH-1:0] local_addr_o,
    input logic [`MESH_DIM*`MESH_DIM-1:0]                       local_ready_i
);

    localparam int NODES = `MESH_DIM * `MESH_DIM;

    // Nothing can have reached a local output yet
    assert property (@(posedge clk) $rose(rst_n) |-> local_valid_o == '0)
        else $error("local_valid_o high in the first cycle after reset");

    for (genvar n = 0; n < NODES; n++) begin : gen_node
        // A stalled output keeps valid until the transfer
        assert property (@(posedge clk) disable iff (!rst_n)
            local_valid_o[n] && !local_ready_i[n] |=> local_valid_o[n])
            else $error("local_valid_o[%0d] fell without a transfer", n);

        assert property (@(posedge clk) disable iff (!rst_n)
            local_valid_o[n] && !local_ready_i[n]
            |=> $stable(local_data_o[n]) && $stable(local_addr_o[n]))
            else $error("local output %0d changed data or addr while stalled", n);
    end

endmodule

// ==== mesh_tb.sv ====
/*
 * Directed, random, back-pressure and random-ready traffic through the 2x2 mesh.
 * Destinations stay inside the mesh; edge-dropped packets would show up as leftovers.
 */
`timescale 1ns/1ps
`include "mesh_config.svh"

module mesh_tb;

    localparam int DIM   = `MESH_DIM;
    localparam int NODES = DIM * DIM;
    localparam int DW    = `MESH_DATA_WIDTH;
    localparam int AW    = `MESH_ADDR_WIDTH;
    localparam int CW    = `MESH_COORD_WIDTH;
    localparam int PW    = AW + DW;
    // About ten times the expected length of all phases together
    localparam int TIMEOUT_CYCLES = 20000;

    logic                      clk;
    logic                      rst_n;
    logic [NODES-1:0]          local_valid_i;
    logic [NODES-1:0][DW-1:0]  local_data_i;
    logic [NODES-1:0][AW-1:0]  local_addr_i;
    logic [NODES-1:0]          local_ready_o;
    logic [NODES-1:0]          local_valid_o;
    logic [NODES-1:0][DW-1:0]  local_data_o;
    logic [NODES-1:0][AW-1:0]  local_addr_o;
    logic [NODES-1:0]          local_ready_i;

    // Packets waiting to be driven, and packets in flight per (source, destination)
    logic [PW-1:0]    pend [NODES][$];
    logic [PW-1:0]    sb   [NODES][NODES][$];
    logic [NODES-1:0] fire_q;
    logic [31:0]      lfsr_state = 32'd39;
    bit               random_send = 1'b0;
    int               ready_mode = 0;
    bit               ready_fell = 1'b0;
    int               errors = 0;
    int               cycles = 0;

    mesh_2x2_top mesh_2x2_top_i (.*);

    bind mesh_2x2_top mesh_properties mesh_properties_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .local_valid_o (local_valid_o),
        .local_data_o  (local_data_o),
        .local_addr_o  (local_addr_o),
        .local_ready_i (local_ready_i)
    );

    // Galois LFSR stepped once per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        logic        lsb;
        val = '0;
        for (int k = 0; k < n; k++) begin
            lsb = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (lsb) begin
                lfsr_state = lfsr_state ^ 32'hB4BC_D35C;
            end
            val = {val[30:0], lsb};
        end
        return val;
    endfunction

    // Node index is y * DIM + x and x sits in the upper half of the address
    function automatic int expected_node(input logic [AW-1:0] addr);
        return int'(addr[CW-1:0]) * DIM + int'(addr[AW-1:CW]);
    endfunction

    function automatic int packets_left();
        int total;
        total = 0;
        for (int s = 0; s < NODES; s++) begin
            total += pend[s].size();
            for (int d = 0; d < NODES; d++) begin
                total += sb[s][d].size();
            end
        end
        return total;
    endfunction

    task automatic queue_packet(input int src, input int dst);
        logic [AW-1:0] addr;
        addr = {CW'(dst % DIM), CW'(dst / DIM)};
        pend[src].push_back({addr, take_bits(DW)});
    endtask

    task automatic wait_idle();
        do begin
            @(negedge clk);
        end while (packets_left() != 0);
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Inputs change only on the rising edge
    initial begin
        logic [PW-1:0] pkt;
        bit            go;
        local_valid_i = '0;
        local_data_i  = '0;
        local_addr_i  = '0;
        local_ready_i = '1;
        forever begin
            @(posedge clk);
            if (rst_n) begin
                for (int s = 0; s < NODES; s++) begin
                    if (!local_valid_i[s] || fire_q[s]) begin
                        go = pend[s].size() > 0;
                        if (go && random_send) begin
                            go = take_bits(1) == 32'd1;
                        end
                        if (go) begin
                            pkt = pend[s].pop_front();
                            local_valid_i[s] <= 1'b1;
                            local_addr_i[s]  <= pkt[PW-1:DW];
                            local_data_i[s]  <= pkt[DW-1:0];
                            sb[s][expected_node(pkt[PW-1:DW])].push_back(pkt);
                        end else begin
                            local_valid_i[s] <= 1'b0;
                        end
                    end
                end
                case (ready_mode)
                    0:       local_ready_i <= '1;
                    1:       local_ready_i <= NODES'(take_bits(NODES));
                    default: local_ready_i <= {1'b0, {(NODES-1){1'b1}}};
                endcase
            end
        end
    end

    // Handshakes are stable on the falling edge
    initial begin
        logic [PW-1:0] got;
        bit            found;
        fire_q = '0;
        forever begin
            @(negedge clk);
            fire_q = local_valid_i & local_ready_o;
            if (ready_mode == 2 && |(local_valid_i[NODES-2:0] & ~local_ready_o[NODES-2:0])) begin
                ready_fell = 1'b1;
            end
            for (int n = 0; n < NODES; n++) begin
                if (rst_n && local_valid_o[n] && local_ready_i[n]) begin
                    got   = {local_addr_o[n], local_data_o[n]};
                    found = 1'b0;
                    for (int s = 0; s < NODES; s++) begin
                        if (!found && sb[s][n].size() > 0 && sb[s][n][0] == got) begin
                            void'(sb[s][n].pop_front());
                            found = 1'b1;
                        end
                    end
                    assert (found) else begin
                        errors++;
                        $display("Error at %0t: node %0d delivered unexpected packet %h",
                                 $time, n, got);
                    end
                    assert (n == expected_node(local_addr_o[n])) else begin
                        errors++;
                        $display("Error at %0t: address %h delivered at node %0d",
                                 $time, local_addr_o[n], n);
                    end
                end
            end
        end
    end

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles with %0d packets still undelivered",
                 cycles, packets_left());
        $display("Finished with errors");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (local_valid_o == '0 && local_ready_o == '1) else begin
            errors++;
            $display("Error at %0t: idle state after reset is wrong, valid %b ready %b",
                     $time, local_valid_o, local_ready_o);
        end

        // Every source to every destination with one packet in flight at a time
        for (int s = 0; s < NODES; s++) begin
            for (int d = 0; d < NODES; d++) begin
                queue_packet(s, d);
                wait_idle();
            end
        end

        random_send = 1'b1;
        for (int k = 0; k < 200; k++) begin
            for (int s = 0; s < NODES; s++) begin
                queue_packet(s, int'(take_bits(2)));
            end
        end
        wait_idle();

        // Node 3 refuses everything while the other nodes flood it
        random_send = 1'b0;
        ready_mode  = 2;
        for (int k = 0; k < 12; k++) begin
            for (int s = 0; s < NODES - 1; s++) begin
                queue_packet(s, NODES - 1);
            end
        end
        repeat (100) @(negedge clk);
        assert (ready_fell && local_valid_o[NODES-1]) else begin
            errors++;
            $display("Back-pressure on node 3 did not stall the senders as expected");
        end
        ready_mode = 0;
        wait_idle();

        random_send = 1'b1;
        ready_mode  = 1;
        for (int k = 0; k < 200; k++) begin
            for (int s = 0; s < NODES; s++) begin
                queue_packet(s, int'(take_bits(2)));
            end
        end
        wait_idle();
        ready_mode = 0;
        repeat (4) @(negedge clk);

        $display("Check errors: %0d, packets left in queues: %0d", errors, packets_left());
        if (errors == 0 && packets_left() == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+.
mesh_pkg.sv
mesh_input_fifo.sv
mesh_rr_arbiter.sv
mesh_router.sv
mesh_2x2_top.sv
mesh_properties.sv
mesh_tb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := mesh_tb
FILELIST := sources.f
OBJ_DIR  := obj_dir
PASS_MSG := Finished with no errors

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
